//--- build.f
mm_pkg.sv
mm_decode.sv
mm_sram.sv
mm_periph.sv
mm_resp_route.sv
test_env.sv
tb_test_env.sv

//--- mm_decode.sv
// combinational arbiter for the core and debug system-bus ports plus the address decoder
`timescale 1ns/1ps

module mm_decode import mm_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = DEFAULT_RAM_ADDR_WIDTH
) (
    // core data port
    input  logic       core_req_i,
    input  logic       core_we_i,
    input  mm_word_t   core_addr_i,
    input  mm_be_t     core_be_i,
    input  mm_word_t   core_wdata_i,
    output logic       core_gnt_o,

    // debug system-bus port
    input  logic       sb_req_i,
    input  logic       sb_we_i,
    input  mm_word_t   sb_addr_i,
    input  mm_be_t     sb_be_i,
    input  mm_word_t   sb_wdata_i,
    output logic       sb_gnt_o,

    // granted access towards the targets
    output logic       acc_valid_o,
    output mm_region_e acc_region_o,
    output logic       acc_sb_o,
    output logic       acc_we_o,
    output mm_word_t   acc_addr_o,
    output mm_be_t     acc_be_o,
    output mm_word_t   acc_wdata_o
);

    // sb has fixed priority, core only wins when sb is idle
    assign sb_gnt_o    = sb_req_i;
    assign core_gnt_o  = core_req_i & ~sb_req_i;
    assign acc_valid_o = sb_req_i | core_req_i;
    assign acc_sb_o    = sb_req_i;

    // request fields of the granted port
    assign acc_we_o    = sb_req_i ? sb_we_i    : core_we_i;
    assign acc_addr_o  = sb_req_i ? sb_addr_i  : core_addr_i;
    assign acc_be_o    = sb_req_i ? sb_be_i    : core_be_i;
    assign acc_wdata_o = sb_req_i ? sb_wdata_i : core_wdata_i;

    always_comb begin
        if (acc_addr_o[31:RAM_ADDR_WIDTH] == '0) begin
            acc_region_o = region_ram;
        end else begin
            unique case (acc_addr_o)
                STDOUT_ADDR: acc_region_o = region_stdout;
                STATUS_ADDR: acc_region_o = region_status;
                HALT_ADDR:   acc_region_o = region_halt;
                // unmapped, answered with a bus error
                default:     acc_region_o = region_none;
            endcase
        end
    end

    // at most one port granted per cycle
    always_comb begin
        assert final (!(core_gnt_o && sb_gnt_o))
            else $error("mm_decode: both ports granted");
    end

endmodule

//--- mm_periph.sv
// memory-mapped stdout, test-status and debug-halt registers of the test environment
`timescale 1ns/1ps

module mm_periph import mm_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       sel_i,
    input  mm_region_e region_i,
    input  logic       we_i,
    input  mm_word_t   wdata_i,
    output mm_word_t   rdata_o,
    output logic       char_valid_o,
    output mm_byte_t   char_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o,
    output logic       debug_req_o
);

    logic stdout_wr;
    logic status_wr;
    logic halt_wr;

    assign stdout_wr = sel_i && we_i && (region_i == region_stdout);
    assign status_wr = sel_i && we_i && (region_i == region_status);
    assign halt_wr   = sel_i && we_i && (region_i == region_halt);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            char_valid_o   <= 1'b0;
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            debug_req_o    <= 1'b0;
        end else begin
            // one-cycle character strobe
            char_valid_o <= stdout_wr;
            // sticky result flags
            if (status_wr) begin
                if (wdata_i == PASS_CODE) begin
                    tests_passed_o <= 1'b1;
                end else begin
                    tests_failed_o <= 1'b1;
                end
            end
            if (halt_wr) begin
                debug_req_o <= wdata_i[0];
            end
        end
    end

    // character byte, only meaningful with the strobe
    always_ff @(posedge clk_i) begin
        if (stdout_wr) begin
            char_o <= wdata_i[7:0];
        end
    end

    // read data, returns the register value before a same-cycle write
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= '0;
            if (region_i == region_status) begin
                rdata_o[STATUS_PASS_BIT] <= tests_passed_o;
                rdata_o[STATUS_FAIL_BIT] <= tests_failed_o;
            end else if (region_i == region_halt) begin
                rdata_o[0] <= debug_req_o;
            end
        end
    end

    // a test reports one result per reset
    a_single_result : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(tests_passed_o && tests_failed_o)
    ) else $error("mm_periph: test reported both pass and fail");

endmodule

//--- mm_pkg.sv
// shared address map, region encoding and bus word types, imported by every RTL module
package mm_pkg;

    // bus word, used for address, write data and read data
    typedef logic [31:0] mm_word_t;

    // one enable bit per byte lane
    typedef logic [3:0] mm_be_t;

    // stdout character
    typedef logic [7:0] mm_byte_t;

    // access targets resolved by the decoder
    typedef enum logic [2:0] {
        region_ram,
        region_stdout,
        region_status,
        region_halt,
        region_none
    } mm_region_e;

    // default RAM size, 4 KiB
    localparam int unsigned DEFAULT_RAM_ADDR_WIDTH = 12;

    // peripheral word addresses
    localparam mm_word_t STDOUT_ADDR = 32'h1000_0000;
    localparam mm_word_t STATUS_ADDR = 32'h2000_0000;
    localparam mm_word_t HALT_ADDR   = 32'h1A11_0000;

    // status value that reports a passing test, anything else is a failure
    localparam mm_word_t PASS_CODE = 32'd123456789;

    // status register read layout
    localparam int unsigned STATUS_PASS_BIT = 0;
    localparam int unsigned STATUS_FAIL_BIT = 1;

endpackage

//--- mm_resp_route.sv
// one-cycle response stage returning rvalid and rdata to the port that was granted
`timescale 1ns/1ps

module mm_resp_route import mm_pkg::*; (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       acc_valid_i,
    input  logic       acc_sb_i,
    input  mm_region_e acc_region_i,
    input  mm_word_t   ram_rdata_i,
    input  mm_word_t   periph_rdata_i,
    output logic       core_rvalid_o,
    output logic       sb_rvalid_o,
    output mm_word_t   core_rdata_o,
    output mm_word_t   sb_rdata_o,
    output logic       bus_err_o
);

    logic       valid_q;
    logic       sb_q;
    mm_region_e region_q;
    mm_word_t   rdata;

    // owner and target of the access granted last cycle
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q  <= 1'b0;
            sb_q     <= 1'b0;
            region_q <= region_none;
        end else begin
            valid_q  <= acc_valid_i;
            sb_q     <= acc_sb_i;
            region_q <= acc_region_i;
        end
    end

    always_comb begin
        unique case (region_q)
            region_ram:  rdata = ram_rdata_i;
            region_none: rdata = '0;
            default:     rdata = periph_rdata_i;
        endcase
    end

    assign core_rvalid_o = valid_q & ~sb_q;
    assign sb_rvalid_o   = valid_q & sb_q;
    assign core_rdata_o  = rdata;
    assign sb_rdata_o    = rdata;
    assign bus_err_o     = valid_q && (region_q == region_none);

    // a response goes to one port only
    a_resp_port : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !(core_rvalid_o && sb_rvalid_o)
    ) else $error("mm_resp_route: rvalid raised on both ports");

endmodule

//--- mm_sram.sv
// byte-enabled single-port RAM behind the decoder, one cycle read latency
`timescale 1ns/1ps

module mm_sram import mm_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = DEFAULT_RAM_ADDR_WIDTH
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     sel_i,
    input  logic     we_i,
    input  mm_word_t addr_i,
    input  mm_be_t   be_i,
    input  mm_word_t wdata_i,
    output mm_word_t rdata_o
);

    localparam int unsigned NUM_WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    mm_word_t                  mem [NUM_WORDS];
    logic [RAM_ADDR_WIDTH-3:0] word_idx;

    // byte address to word index
    assign word_idx = addr_i[RAM_ADDR_WIDTH-1:2];

    // only enabled lanes are written
    always_ff @(posedge clk_i) begin
        if (sel_i && we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
    end

    // read on every selected access, a write sees the old word
    always_ff @(posedge clk_i) begin
        if (sel_i) begin
            rdata_o <= mem[word_idx];
        end
    end

    // a write with no byte enabled is a requester bug
    a_write_be_nonzero : assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (sel_i && we_i) |-> (be_i != '0)
    ) else $error("mm_sram: write with empty byte enable at %h", addr_i);

endmodule

//--- run.sh
#!/bin/sh
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_test_env
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out="$(./obj_dir/Vtb_test_env)"
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASSED"; then
    exit 0
fi
exit 1

//--- tb_test_env.sv
// testbench for test_env, replays test_env_vectors.txt and then runs seeded two-port traffic
`timescale 1ns/1ps

module tb_test_env import mm_pkg::*; ();

    localparam int unsigned RAM_ADDR_WIDTH = 12;
    localparam int          VEC_COLS       = 7;
    localparam int          VEC_WORDS      = 512;
    localparam int          WIN_WORDS      = 16;
    localparam int          NUM_PAIRS      = 24;
    localparam mm_word_t    WIN_BASE       = 32'h0000_0200;

    logic     clk;
    logic     rst_n;
    logic     core_req, core_we, core_gnt, core_rvalid;
    mm_word_t core_addr, core_wdata, core_rdata;
    mm_be_t   core_be;
    logic     sb_req, sb_we, sb_gnt, sb_rvalid;
    mm_word_t sb_addr, sb_wdata, sb_rdata;
    mm_be_t   sb_be;
    logic     char_valid, tests_passed, tests_failed, debug_req, bus_err;
    mm_byte_t char_out;

    // vector columns: port, we, addr, be, wdata, expected rdata, side-effect code
    mm_word_t vec_mem [VEC_WORDS];
    // reference RAM for the random window
    mm_word_t ram_ref [2 ** (RAM_ADDR_WIDTH - 2)];

    int   seed;
    int   num_vec;
    int   cycle_count = 0;
    int   cycle_limit;
    int   check_count = 0;
    int   error_count = 0;
    int   word_errors = 0;
    int   flag_errors = 0;
    int   char_errors = 0;
    logic exp_passed, exp_failed, exp_debug;

    test_env #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) dut0 (
        .clk_i(clk), .rst_ni(rst_n),
        .core_req_i(core_req), .core_gnt_o(core_gnt), .core_rvalid_o(core_rvalid),
        .core_we_i(core_we), .core_addr_i(core_addr), .core_be_i(core_be),
        .core_wdata_i(core_wdata), .core_rdata_o(core_rdata),
        .sb_req_i(sb_req), .sb_gnt_o(sb_gnt), .sb_rvalid_o(sb_rvalid),
        .sb_we_i(sb_we), .sb_addr_i(sb_addr), .sb_be_i(sb_be),
        .sb_wdata_i(sb_wdata), .sb_rdata_o(sb_rdata),
        .char_valid_o(char_valid), .char_o(char_out), .tests_passed_o(tests_passed),
        .tests_failed_o(tests_failed), .debug_req_o(debug_req), .bus_err_o(bus_err)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_word(input string name, input mm_word_t got, input mm_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            word_errors++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            flag_errors++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_char(input string name, input mm_byte_t got, input mm_byte_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            char_errors++;
            $display("ERROR %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic ref_ram_access(input logic we, input mm_word_t addr, input mm_be_t be,
                                  input mm_word_t wdata, output mm_word_t old);
        logic [RAM_ADDR_WIDTH-3:0] idx;
        idx = addr[RAM_ADDR_WIDTH-1:2];
        old = ram_ref[idx];
        if (we) begin
            for (int b = 0; b < 4; b++) begin
                if (be[b]) begin
                    ram_ref[idx][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
        end
    endtask

    task automatic drive_port(input logic to_sb, input logic req, input logic we,
                              input mm_word_t addr, input mm_be_t be, input mm_word_t wdata);
        if (to_sb) begin
            sb_req   <= req;
            sb_we    <= we;
            sb_addr  <= addr;
            sb_be    <= be;
            sb_wdata <= wdata;
        end else begin
            core_req   <= req;
            core_we    <= we;
            core_addr  <= addr;
            core_be    <= be;
            core_wdata <= wdata;
        end
    endtask

    // effect codes: 2 char, 3 pass, 4 fail, 5 halt level, 6 bus error
    task automatic check_side(input int effect, input mm_word_t wdata);
        case (effect)
            3:       exp_passed = 1'b1;
            4:       exp_failed = 1'b1;
            5:       exp_debug  = wdata[0];
            default: ;
        endcase
        check_flag("char_valid_o", char_valid, effect == 2);
        if (effect == 2) begin
            check_char("char_o", char_out, wdata[7:0]);
        end
        check_flag("bus_err_o", bus_err, effect == 6);
        check_flag("tests_passed_o", tests_passed, exp_passed);
        check_flag("tests_failed_o", tests_failed, exp_failed);
        check_flag("debug_req_o", debug_req, exp_debug);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        exp_passed = 1'b0;
        exp_failed = 1'b0;
        exp_debug  = 1'b0;
        @(negedge clk);
        check_flag("core_gnt_o", core_gnt, 1'b0);
        check_flag("sb_gnt_o", sb_gnt, 1'b0);
        check_flag("core_rvalid_o", core_rvalid, 1'b0);
        check_flag("sb_rvalid_o", sb_rvalid, 1'b0);
        check_side(0, '0);
    endtask

    // one access on one port, answered one cycle after its grant
    task automatic run_access(input logic to_sb, input logic we, input mm_word_t addr,
                              input mm_be_t be, input mm_word_t wdata, input logic chk,
                              input mm_word_t exp_rdata, input int effect);
        string own;
        string other;
        own   = to_sb ? "sb_" : "core_";
        other = to_sb ? "core_" : "sb_";
        @(posedge clk);
        drive_port(to_sb, 1'b1, we, addr, be, wdata);
        @(negedge clk);
        while ((to_sb && !sb_gnt) || (!to_sb && !core_gnt)) begin
            @(negedge clk);
        end
        check_flag({other, "gnt_o"}, to_sb ? core_gnt : sb_gnt, 1'b0);
        // a char strobe from the previous access must be gone by now
        check_flag("char_valid_o", char_valid, 1'b0);
        @(posedge clk);
        drive_port(to_sb, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag({own, "rvalid_o"}, to_sb ? sb_rvalid : core_rvalid, 1'b1);
        check_flag({other, "rvalid_o"}, to_sb ? core_rvalid : sb_rvalid, 1'b0);
        if (chk) begin
            check_word({own, "rdata_o"}, to_sb ? sb_rdata : core_rdata, exp_rdata);
        end
        check_side(effect, wdata);
    endtask

    // both ports request in the same cycle, sb wins and core follows
    task automatic run_pair();
        mm_word_t r;
        mm_word_t sb_a, sb_d, sb_exp;
        mm_word_t core_a, core_d, core_exp;
        mm_be_t   sb_b, core_b;
        logic     sb_w, core_w;
        r      = $random(seed);
        sb_w   = r[4];
        core_w = r[5];
        sb_a   = WIN_BASE + (mm_word_t'(r[3:0]) << 2);
        core_a = WIN_BASE + (mm_word_t'(r[9:6]) << 2);
        sb_b   = (sb_w && r[13:10] != '0) ? r[13:10] : 4'hF;
        core_b = (core_w && r[17:14] != '0) ? r[17:14] : 4'hF;
        sb_d   = $random(seed);
        core_d = $random(seed);
        ref_ram_access(sb_w, sb_a, sb_b, sb_d, sb_exp);
        ref_ram_access(core_w, core_a, core_b, core_d, core_exp);
        @(posedge clk);
        drive_port(1'b1, 1'b1, sb_w, sb_a, sb_b, sb_d);
        drive_port(1'b0, 1'b1, core_w, core_a, core_b, core_d);
        @(negedge clk);
        check_flag("sb_gnt_o", sb_gnt, 1'b1);
        check_flag("core_gnt_o", core_gnt, 1'b0);
        @(posedge clk);
        drive_port(1'b1, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag("core_gnt_o", core_gnt, 1'b1);
        check_flag("sb_rvalid_o", sb_rvalid, 1'b1);
        check_flag("core_rvalid_o", core_rvalid, 1'b0);
        check_word("sb_rdata_o", sb_rdata, sb_exp);
        @(posedge clk);
        drive_port(1'b0, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag("core_rvalid_o", core_rvalid, 1'b1);
        check_flag("sb_rvalid_o", sb_rvalid, 1'b0);
        check_word("core_rdata_o", core_rdata, core_exp);
        check_side(0, '0);
    endtask

    initial begin
        mm_word_t old;
        mm_word_t addr;
        mm_word_t data;
        int       b;
        seed = 32'h4e30c7a8;
        rst_n <= 1'b0;
        drive_port(1'b0, 1'b0, 1'b0, '0, '0, '0);
        drive_port(1'b1, 1'b0, 1'b0, '0, '0, '0);
        for (int i = 0; i < VEC_WORDS; i++) begin
            vec_mem[i] = '1;
        end
        $readmemh("test_env_vectors.txt", vec_mem);
        num_vec = 0;
        while ((num_vec + 1) * VEC_COLS <= VEC_WORDS && vec_mem[num_vec * VEC_COLS] != '1) begin
            num_vec++;
        end
        if (num_vec == 0) begin
            $display("no vectors were read from test_env_vectors.txt");
            error_count++;
        end
        cycle_limit = (num_vec + WIN_WORDS + 2 * NUM_PAIRS) * 4 + 50;
        apply_reset();

        // port 2 in the vector file requests a fresh reset
        for (int v = 0; v < num_vec; v++) begin
            b = v * VEC_COLS;
            if (vec_mem[b] == 32'd2) begin
                apply_reset();
            end else begin
                run_access(vec_mem[b][0], vec_mem[b + 1][0], vec_mem[b + 2],
                           vec_mem[b + 3][3:0], vec_mem[b + 4], vec_mem[b + 6] != 32'd1,
                           vec_mem[b + 5], vec_mem[b + 6]);
            end
        end

        // fill the random window so every later read is predictable
        for (int w = 0; w < WIN_WORDS; w++) begin
            addr = WIN_BASE + mm_word_t'(w * 4);
            data = $random(seed);
            ref_ram_access(1'b1, addr, 4'hF, data, old);
            run_access(1'b0, 1'b1, addr, 4'hF, data, 1'b0, old, 0);
        end
        repeat (NUM_PAIRS) begin
            run_pair();
        end

        $display("checks: %0d, errors: %0d (word %0d, flag %0d, char %0d)",
                 check_count, error_count, word_errors, flag_errors, char_errors);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- test_env.sv
// top level of the memory-mapped test environment, driven by the testbench through both bus ports
`timescale 1ns/1ps

module test_env import mm_pkg::*; #(
    parameter int unsigned RAM_ADDR_WIDTH = DEFAULT_RAM_ADDR_WIDTH
) (
    input  logic     clk_i,
    input  logic     rst_ni,

    // core data port
    input  logic     core_req_i,
    output logic     core_gnt_o,
    output logic     core_rvalid_o,
    input  logic     core_we_i,
    input  mm_word_t core_addr_i,
    input  mm_be_t   core_be_i,
    input  mm_word_t core_wdata_i,
    output mm_word_t core_rdata_o,

    // debug system-bus port
    input  logic     sb_req_i,
    output logic     sb_gnt_o,
    output logic     sb_rvalid_o,
    input  logic     sb_we_i,
    input  mm_word_t sb_addr_i,
    input  mm_be_t   sb_be_i,
    input  mm_word_t sb_wdata_i,
    output mm_word_t sb_rdata_o,

    // side outputs
    output logic     char_valid_o,
    output mm_byte_t char_o,
    output logic     tests_passed_o,
    output logic     tests_failed_o,
    output logic     debug_req_o,
    output logic     bus_err_o
);

    logic       acc_valid;
    mm_region_e acc_region;
    logic       acc_sb;
    logic       acc_we;
    mm_word_t   acc_addr;
    mm_be_t     acc_be;
    mm_word_t   acc_wdata;
    logic       ram_sel;
    mm_word_t   ram_rdata;
    mm_word_t   periph_rdata;

    mm_decode #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) decode_i (
        .core_req_i(core_req_i), .core_we_i(core_we_i), .core_addr_i(core_addr_i),
        .core_be_i(core_be_i), .core_wdata_i(core_wdata_i), .core_gnt_o(core_gnt_o),
        .sb_req_i(sb_req_i), .sb_we_i(sb_we_i), .sb_addr_i(sb_addr_i),
        .sb_be_i(sb_be_i), .sb_wdata_i(sb_wdata_i), .sb_gnt_o(sb_gnt_o),
        .acc_valid_o(acc_valid), .acc_region_o(acc_region), .acc_sb_o(acc_sb),
        .acc_we_o(acc_we), .acc_addr_o(acc_addr), .acc_be_o(acc_be),
        .acc_wdata_o(acc_wdata)
    );

    // RAM select from the decoded region
    assign ram_sel = acc_valid && (acc_region == region_ram);

    mm_sram #(.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)) sram_i (
        .clk_i(clk_i), .rst_ni(rst_ni), .sel_i(ram_sel), .we_i(acc_we),
        .addr_i(acc_addr), .be_i(acc_be), .wdata_i(acc_wdata), .rdata_o(ram_rdata)
    );

    mm_periph periph_i (
        .clk_i(clk_i), .rst_ni(rst_ni), .sel_i(acc_valid), .region_i(acc_region),
        .we_i(acc_we), .wdata_i(acc_wdata), .rdata_o(periph_rdata),
        .char_valid_o(char_valid_o), .char_o(char_o), .tests_passed_o(tests_passed_o),
        .tests_failed_o(tests_failed_o), .debug_req_o(debug_req_o)
    );

    mm_resp_route resp_route_i (
        .clk_i(clk_i), .rst_ni(rst_ni), .acc_valid_i(acc_valid), .acc_sb_i(acc_sb),
        .acc_region_i(acc_region), .ram_rdata_i(ram_rdata), .periph_rdata_i(periph_rdata),
        .core_rvalid_o(core_rvalid_o), .sb_rvalid_o(sb_rvalid_o),
        .core_rdata_o(core_rdata_o), .sb_rdata_o(sb_rdata_o), .bus_err_o(bus_err_o)
    );

endmodule

//--- test_env_vectors.txt
// columns: port (0 core, 1 sb, 2 reset) we addr be wdata expected_rdata effect
// effect: 0 none, 1 rdata unchecked, 2 stdout char, 3 pass, 4 fail, 5 halt level, 6 bus error
0 1 00000010 F 11223344 00000000 1
1 0 00000010 F 00000000 11223344 0
0 1 00000010 3 0000AABB 11223344 0
0 0 00000010 F 00000000 1122AABB 0
1 1 00000010 8 EE000000 1122AABB 0
1 0 00000010 F 00000000 EE22AABB 0
1 1 00000014 F CAFEF00D 00000000 1
0 1 00000014 2 00005500 CAFEF00D 0
0 0 00000014 F 00000000 CAFE550D 0
0 1 00000FFC F 0BADBEEF 00000000 1
1 0 00000FFC F 00000000 0BADBEEF 0
0 1 10000000 F 00000048 00000000 2
1 1 10000000 1 0000ABCD 00000000 2
0 0 10000000 F 00000000 00000000 0
1 1 1A110000 F 00000001 00000000 5
1 0 1A110000 F 00000000 00000001 0
1 1 1A110000 F 00000000 00000001 5
0 0 1A110000 F 00000000 00000000 0
0 1 30000010 F 12345678 00000000 6
1 0 00001010 F 00000000 00000000 6
0 0 00000010 F 00000000 EE22AABB 0
1 1 20000000 F 075BCD15 00000000 3
0 0 20000000 F 00000000 00000001 0
0 1 00000010 F 55667788 EE22AABB 0
1 0 00000010 F 00000000 55667788 0
2 0 00000000 0 00000000 00000000 0
0 1 20000000 F 00000001 00000000 4
1 0 20000000 F 00000000 00000002 0
